// File: Makefile
TOP = fft_conv_pe_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f fft_conv_pe.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: common/conv_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface conv_ctrl_if #(
    parameter int CHANNELS = 3
);

    // keep one bit even for a single channel
    localparam int CH_WIDTH = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

    // stage enables, one cycle each
    logic                forward_en;
    logic                multiply_en;
    logic                inverse_en;
    logic                accumulate_en;
    // channel in work
    logic [CH_WIDTH-1:0] channel;
    logic                last_channel;

    modport sequencer (
        output forward_en, multiply_en, inverse_en, accumulate_en,
        input  last_channel
    );

    modport counter (
        input  accumulate_en,
        output channel, last_channel
    );

    modport datapath (
        input forward_en, multiply_en, inverse_en, accumulate_en, channel
    );

endinterface

`default_nettype wire

// File: common/fft_conv_pkg.sv
`default_nettype none

package fft_conv_pkg;

    // ==============================
    // block sizes
    // ==============================

    // twiddle tables below only hold for a 4-point transform
    localparam int TILE_SIZE   = 4;
    localparam int KERNEL_SIZE = 3;
    // edge of the region where circular and linear convolution agree
    localparam int OUT_SIZE    = TILE_SIZE - KERNEL_SIZE + 1;

    // ==============================
    // widths
    // ==============================

    localparam int PIXEL_WIDTH  = 8;
    localparam int WEIGHT_WIDTH = 8;
    // 16 terms of +-1 times an 8-bit value
    localparam int SPEC_WIDTH   = 12;
    // 12 x 13 bit product plus one bit for the P+Q sum
    localparam int PROD_WIDTH   = 26;
    // inverse sums before the divide by 16
    localparam int IDFT_WIDTH   = 30;
    localparam int OUT_WIDTH    = 29;

    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [SPEC_WIDTH-1:0]   spec_t;
    typedef logic signed [PROD_WIDTH-1:0]   prod_t;
    typedef logic signed [IDFT_WIDTH-1:0]   idft_t;
    typedef logic signed [OUT_WIDTH-1:0]    out_t;
    // holds -1, 0 or +1
    typedef logic signed [1:0]              coeff_t;

    // one state per registered stage, done parks the engine
    typedef enum logic [2:0] {
        FORWARD,
        MULTIPLY,
        INVERSE,
        ACCUMULATE,
        DONE
    } stage_e;

    // ==============================
    // twiddles exp(-j*2*pi*k*n/4)
    // ==============================

    // 2'sb11 is -1
    localparam coeff_t TWIDDLE_RE [TILE_SIZE][TILE_SIZE] = '{
        '{2'sb01, 2'sb01, 2'sb01, 2'sb01},
        '{2'sb01, 2'sb00, 2'sb11, 2'sb00},
        '{2'sb01, 2'sb11, 2'sb01, 2'sb11},
        '{2'sb01, 2'sb00, 2'sb11, 2'sb00}
    };

    // inverse transform uses this with the sign flipped
    localparam coeff_t TWIDDLE_IM [TILE_SIZE][TILE_SIZE] = '{
        '{2'sb00, 2'sb00, 2'sb00, 2'sb00},
        '{2'sb00, 2'sb11, 2'sb00, 2'sb01},
        '{2'sb00, 2'sb00, 2'sb00, 2'sb00},
        '{2'sb00, 2'sb01, 2'sb00, 2'sb11}
    };

endpackage

`default_nettype wire

// File: design/channel_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module channel_accumulator (
    input  logic                clk,
    input  logic                reset,
    conv_ctrl_if.datapath       ctrl,
    input  fft_conv_pkg::idft_t block [fft_conv_pkg::OUT_SIZE][fft_conv_pkg::OUT_SIZE],
    output fft_conv_pkg::out_t [fft_conv_pkg::OUT_SIZE*fft_conv_pkg::OUT_SIZE-1:0] out_data
);

    localparam int M = fft_conv_pkg::OUT_SIZE;

    // one running sum per output position, index i*2+j
    // cleared only by reset, so a run starts from zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_data <= '0;
        end else if (ctrl.accumulate_en) begin
            for (int i = 0; i < M; i++) begin
                for (int j = 0; j < M; j++) begin
                    out_data[i*M+j] <= out_data[i*M+j]
                                     + fft_conv_pkg::out_t'(block[i][j]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/channel_counter.sv
`timescale 1ns/10ps
`default_nettype none

module channel_counter #(
    parameter int CHANNELS = 3
) (
    input  logic         clk,
    input  logic         reset,
    conv_ctrl_if.counter ctrl
);

    // step to the next channel as its block is accumulated
    // on the last channel the sequencer stops instead
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl.channel <= '0;
        end else if (ctrl.accumulate_en && !ctrl.last_channel) begin
            ctrl.channel <= ctrl.channel + 1'b1;
        end
    end

    assign ctrl.last_channel = (int'(ctrl.channel) == CHANNELS - 1);

    // an out of range channel would read past the input vectors
    assert property (@(posedge clk) disable iff (reset) int'(ctrl.channel) < CHANNELS)
        else $error("channel index reached CHANNELS");

endmodule

`default_nettype wire

// File: design/fft_conv_pe.sv
`timescale 1ns/10ps
`default_nettype none

module fft_conv_pe #(
    parameter int CHANNELS = 3
) (
    input  logic clk,
    input  logic reset,
    // channel 0, row 0, column 0 at the top
    input  logic [CHANNELS*fft_conv_pkg::TILE_SIZE*fft_conv_pkg::TILE_SIZE
                  *fft_conv_pkg::PIXEL_WIDTH-1:0] tile,
    input  logic [CHANNELS*fft_conv_pkg::KERNEL_SIZE*fft_conv_pkg::KERNEL_SIZE
                  *fft_conv_pkg::WEIGHT_WIDTH-1:0] kernel,
    // element (i,j) at index i*2+j
    output fft_conv_pkg::out_t [fft_conv_pkg::OUT_SIZE*fft_conv_pkg::OUT_SIZE-1:0] out_data,
    output logic done
);

    localparam int N = fft_conv_pkg::TILE_SIZE;
    localparam int M = fft_conv_pkg::OUT_SIZE;

    fft_conv_pkg::spec_t tile_re [N][N];
    fft_conv_pkg::spec_t tile_im [N][N];
    fft_conv_pkg::spec_t kern_re [N][N];
    fft_conv_pkg::spec_t kern_im [N][N];
    fft_conv_pkg::prod_t prod_re [N][N];
    fft_conv_pkg::prod_t prod_im [N][N];
    fft_conv_pkg::idft_t block   [M][M];

    conv_ctrl_if #(.CHANNELS(CHANNELS)) ctrl ();

    // ==============================
    // control
    // ==============================

    stage_sequencer u_sequencer (
        .clk(clk), .reset(reset), .ctrl(ctrl.sequencer), .done(done)
    );

    channel_counter #(.CHANNELS(CHANNELS)) u_counter (
        .clk(clk), .reset(reset), .ctrl(ctrl.counter)
    );

    // ==============================
    // datapath
    // ==============================

    dft4_forward #(
        .CHANNELS(CHANNELS), .ELEM_WIDTH(fft_conv_pkg::PIXEL_WIDTH), .BLOCK_SIZE(N)
    ) u_tile_dft (
        .clk(clk), .reset(reset), .ctrl(ctrl.datapath),
        .block(tile), .spec_re(tile_re), .spec_im(tile_im)
    );

    // kernel is zero-padded to the tile edge inside
    dft4_forward #(
        .CHANNELS(CHANNELS), .ELEM_WIDTH(fft_conv_pkg::WEIGHT_WIDTH),
        .BLOCK_SIZE(fft_conv_pkg::KERNEL_SIZE)
    ) u_kern_dft (
        .clk(clk), .reset(reset), .ctrl(ctrl.datapath),
        .block(kernel), .spec_re(kern_re), .spec_im(kern_im)
    );

    spectral_multiplier u_multiplier (
        .clk(clk), .reset(reset), .ctrl(ctrl.datapath),
        .tile_re(tile_re), .tile_im(tile_im), .kern_re(kern_re), .kern_im(kern_im),
        .prod_re(prod_re), .prod_im(prod_im)
    );

    dft4_inverse_crop u_inverse (
        .clk(clk), .reset(reset), .ctrl(ctrl.datapath),
        .prod_re(prod_re), .prod_im(prod_im), .block(block)
    );

    channel_accumulator u_accumulator (
        .clk(clk), .reset(reset), .ctrl(ctrl.datapath),
        .block(block), .out_data(out_data)
    );

endmodule

`default_nettype wire

// File: design/stage_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module stage_sequencer (
    input  logic           clk,
    input  logic           reset,
    conv_ctrl_if.sequencer ctrl,
    output logic           done
);

    fft_conv_pkg::stage_e state;
    fft_conv_pkg::stage_e state_next;

    // ==============================
    // next state
    // ==============================

    always_comb begin
        case (state)
            fft_conv_pkg::FORWARD:    state_next = fft_conv_pkg::MULTIPLY;
            fft_conv_pkg::MULTIPLY:   state_next = fft_conv_pkg::INVERSE;
            fft_conv_pkg::INVERSE:    state_next = fft_conv_pkg::ACCUMULATE;
            fft_conv_pkg::ACCUMULATE: begin
                // loop back for the next channel or stop
                if (ctrl.last_channel) begin
                    state_next = fft_conv_pkg::DONE;
                end else begin
                    state_next = fft_conv_pkg::FORWARD;
                end
            end
            // done is held until reset
            default:                  state_next = fft_conv_pkg::DONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= fft_conv_pkg::FORWARD;
        end else begin
            state <= state_next;
        end
    end

    // ==============================
    // stage decode
    // ==============================

    assign ctrl.forward_en    = (state == fft_conv_pkg::FORWARD);
    assign ctrl.multiply_en   = (state == fft_conv_pkg::MULTIPLY);
    assign ctrl.inverse_en    = (state == fft_conv_pkg::INVERSE);
    assign ctrl.accumulate_en = (state == fft_conv_pkg::ACCUMULATE);
    assign done               = (state == fft_conv_pkg::DONE);

    // exactly one stage enable or done is high at any time
    // an illegal state code would leave all of them low
    assert property (@(posedge clk) disable iff (reset)
        $onehot({ctrl.forward_en, ctrl.multiply_en, ctrl.inverse_en, ctrl.accumulate_en, done}))
        else $error("stage decode not one-hot");

endmodule

`default_nettype wire

// File: fft_conv_pe.f
common/fft_conv_pkg.sv
common/conv_ctrl_if.sv
design/stage_sequencer.sv
design/channel_counter.sv
transform/dft4_forward.sv
transform/spectral_multiplier.sv
transform/dft4_inverse_crop.sv
design/channel_accumulator.sv
design/fft_conv_pe.sv
sim/fft_conv_pe_tb.sv

// File: sim/fft_conv_pe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fft_conv_pe_tb;

    localparam int CHANNELS       = 3;
    localparam int N              = fft_conv_pkg::TILE_SIZE;
    localparam int K              = fft_conv_pkg::KERNEL_SIZE;
    localparam int M              = fft_conv_pkg::OUT_SIZE;
    localparam int TILE_BITS      = CHANNELS * N * N * fft_conv_pkg::PIXEL_WIDTH;
    localparam int KERN_BITS      = CHANNELS * K * K * fft_conv_pkg::WEIGHT_WIDTH;
    // four single-cycle stages per channel
    localparam int DONE_CYCLES    = 4 * CHANNELS;
    localparam int RESET_CYCLES   = 16;
    localparam int HOLD_CYCLES    = 20;
    localparam int TIMEOUT_CYCLES = 100;

    typedef fft_conv_pkg::out_t [M*M-1:0] out_vec_t;

    logic                 clk;
    logic                 reset;
    logic [TILE_BITS-1:0] tile;
    logic [KERN_BITS-1:0] kernel;
    out_vec_t             out_data;
    logic                 done;

    // one-cycle pulses that arm the result checks
    logic     check_now;
    logic     repeat_check;
    out_vec_t expected_data;
    out_vec_t previous_data;
    string    case_name;
    int       cycles_since_release;
    int       value_errors;
    int       protocol_errors;
    int       timeout_errors;
    logic     timed_out;
    logic [31:0] lcg_state;

    fft_conv_pe #(.CHANNELS(CHANNELS)) i_dut (
        .clk(clk), .reset(reset), .tile(tile), .kernel(kernel),
        .out_data(out_data), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // edges since reset release, saturating
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles_since_release <= 0;
        end else if (cycles_since_release < 1000) begin
            cycles_since_release <= cycles_since_release + 1;
        end
    end

    // ==============================
    // checks
    // ==============================

    assert property (@(posedge clk) reset |-> !done)
        else begin
            protocol_errors++;
            $display("done was high while reset was asserted");
        end

    // done must appear after exactly one pass per channel
    assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> cycles_since_release == DONE_CYCLES)
        else begin
            value_errors++;
            $display("ERROR done rise cycle: got %h expected %h",
                     $sampled(cycles_since_release), DONE_CYCLES);
        end

    assert property (@(posedge clk) $fell(done) |-> reset)
        else begin
            protocol_errors++;
            $display("done dropped without a reset");
        end

    // result is held once finished
    assert property (@(posedge clk) disable iff (reset)
        (done && $past(done)) |-> $stable(out_data))
        else begin
            protocol_errors++;
            $display("out_data changed while done was high");
        end

    assert property (@(posedge clk) check_now |-> out_data == expected_data)
        else begin
            value_errors++;
            $display("ERROR out_data (%s): got %h expected %h",
                     case_name, out_data, expected_data);
        end

    // accumulators must restart at zero after reset
    assert property (@(posedge clk) repeat_check |-> out_data == previous_data)
        else begin
            value_errors++;
            $display("ERROR out_data repeat (%s): got %h expected %h",
                     case_name, out_data, previous_data);
        end

    // ==============================
    // stimulus helpers
    // ==============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // channel 0, element (0,0) is the top byte
    function automatic int tile_at(input logic [TILE_BITS-1:0] t, input int ch,
                                   input int r, input int c);
        logic signed [7:0] v;
        v = t[(CHANNELS*N*N - 1 - (ch*N*N + r*N + c))*8 +: 8];
        return int'(v);
    endfunction

    function automatic int kern_at(input logic [KERN_BITS-1:0] k, input int ch,
                                   input int m, input int n);
        logic signed [7:0] v;
        v = k[(CHANNELS*K*K - 1 - (ch*K*K + m*K + n))*8 +: 8];
        return int'(v);
    endfunction

    // valid linear convolution summed over channels
    function automatic out_vec_t reference_conv(input logic [TILE_BITS-1:0] t,
                                                input logic [KERN_BITS-1:0] k);
        out_vec_t result;
        int       sum;
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < M; j++) begin
                sum = 0;
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    for (int m = 0; m < K; m++) begin
                        for (int n = 0; n < K; n++) begin
                            sum += tile_at(t, ch, i + K - 1 - m, j + K - 1 - n)
                                 * kern_at(k, ch, m, n);
                        end
                    end
                end
                result[i*M+j] = fft_conv_pkg::out_t'(sum);
            end
        end
        return result;
    endfunction

    task automatic fill_random(output logic [TILE_BITS-1:0] t,
                               output logic [KERN_BITS-1:0] k);
        logic [31:0] r;
        for (int b = 0; b < TILE_BITS / 8; b++) begin
            r = lcg_next();
            t[b*8 +: 8] = r[23:16];
        end
        for (int b = 0; b < KERN_BITS / 8; b++) begin
            r = lcg_next();
            k[b*8 +: 8] = r[23:16];
        end
    endtask

    // reset, load inputs, wait for done, pulse the checks, then hold
    task automatic run_case(input string name, input logic [TILE_BITS-1:0] t,
                            input logic [KERN_BITS-1:0] k, input out_vec_t expected,
                            input logic compare_previous);
        int waited;
        if (timed_out) begin
            return;
        end
        case_name = name;
        expected_data = expected;
        @(posedge clk);
        reset <= 1'b1;
        tile <= t;
        kernel <= k;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!done) begin
            timed_out = 1'b1;
            timeout_errors++;
            $display("done did not rise within %0d cycles in case %s", TIMEOUT_CYCLES, name);
            return;
        end
        check_now <= 1'b1;
        repeat_check <= compare_previous;
        @(posedge clk);
        check_now <= 1'b0;
        repeat_check <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        logic [TILE_BITS-1:0] t;
        logic [KERN_BITS-1:0] k;
        out_vec_t             expected;
        reset = 1'b1;
        tile = '0;
        kernel = '0;
        check_now = 1'b0;
        repeat_check = 1'b0;
        previous_data = '0;
        expected_data = '0;
        case_name = "";
        value_errors = 0;
        protocol_errors = 0;
        timeout_errors = 0;
        timed_out = 1'b0;
        lcg_state = 32'd85428;

        // identity kernel picks the bottom right 2x2 of channel 0
        fill_random(t, k);
        k = '0;
        k[KERN_BITS-1 -: 8] = 8'd1;
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < M; j++) begin
                expected[i*M+j] = fft_conv_pkg::out_t'(tile_at(t, 0, i + K - 1, j + K - 1));
            end
        end
        run_case("identity", t, k, expected, 1'b0);

        for (int run = 0; run < 20; run++) begin
            fill_random(t, k);
            run_case("random", t, k, reference_conv(t, k), 1'b0);
        end

        // same inputs again after a reset
        previous_data = out_data;
        run_case("repeat", t, k, reference_conv(t, k), 1'b1);

        // largest magnitude at every position
        t = {(TILE_BITS / 8){8'h80}};
        k = {(KERN_BITS / 8){8'h80}};
        expected = {(M * M){fft_conv_pkg::out_t'(CHANNELS * K * K * 16384)}};
        run_case("all_min", t, k, expected, 1'b0);

        $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: transform/dft4_forward.sv
`timescale 1ns/10ps
`default_nettype none

module dft4_forward #(
    parameter int CHANNELS   = 3,
    parameter int ELEM_WIDTH = 8,
    // 4 for the tile, 3 for the kernel
    parameter int BLOCK_SIZE = 4
) (
    input  logic                clk,
    input  logic                reset,
    conv_ctrl_if.datapath       ctrl,
    input  logic [CHANNELS*BLOCK_SIZE*BLOCK_SIZE*ELEM_WIDTH-1:0] block,
    output fft_conv_pkg::spec_t spec_re [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    output fft_conv_pkg::spec_t spec_im [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE]
);

    localparam int N     = fft_conv_pkg::TILE_SIZE;
    localparam int ELEMS = CHANNELS * BLOCK_SIZE * BLOCK_SIZE;

    fft_conv_pkg::spec_t padded [N][N];
    fft_conv_pkg::spec_t row_re [N][N];
    fft_conv_pkg::spec_t row_im [N][N];
    fft_conv_pkg::spec_t col_re [N][N];
    fft_conv_pkg::spec_t col_im [N][N];

    // ==============================
    // channel select and padding
    // ==============================

    // channel 0, element (0,0) sits at the top of the flat vector
    always_comb begin
        int flat_idx;
        flat_idx = 0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                padded[r][c] = '0;
                if (r < BLOCK_SIZE && c < BLOCK_SIZE) begin
                    flat_idx = ELEMS - 1
                             - (int'(ctrl.channel) * BLOCK_SIZE * BLOCK_SIZE
                                + r * BLOCK_SIZE + c);
                    padded[r][c] = fft_conv_pkg::spec_t'(
                        signed'(block[flat_idx*ELEM_WIDTH +: ELEM_WIDTH]));
                end
            end
        end
    end

    // ==============================
    // 2-D transform
    // ==============================

    always_comb begin
        // rows, real input so one multiply per table
        for (int r = 0; r < N; r++) begin
            for (int k = 0; k < N; k++) begin
                row_re[r][k] = '0;
                row_im[r][k] = '0;
                for (int c = 0; c < N; c++) begin
                    row_re[r][k] += padded[r][c]
                                  * fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_RE[k][c]);
                    row_im[r][k] += padded[r][c]
                                  * fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_IM[k][c]);
                end
            end
        end
        // columns, full complex product with the twiddles
        for (int l = 0; l < N; l++) begin
            for (int k = 0; k < N; k++) begin
                col_re[l][k] = '0;
                col_im[l][k] = '0;
                for (int r = 0; r < N; r++) begin
                    col_re[l][k] += fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_RE[l][r])
                                  * row_re[r][k]
                                  - fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_IM[l][r])
                                  * row_im[r][k];
                    col_im[l][k] += fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_RE[l][r])
                                  * row_im[r][k]
                                  + fft_conv_pkg::spec_t'(fft_conv_pkg::TWIDDLE_IM[l][r])
                                  * row_re[r][k];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spec_re <= '{default: '0};
            spec_im <= '{default: '0};
        end else if (ctrl.forward_en) begin
            spec_re <= col_re;
            spec_im <= col_im;
        end
    end

endmodule

`default_nettype wire

// File: transform/dft4_inverse_crop.sv
`timescale 1ns/10ps
`default_nettype none

module dft4_inverse_crop (
    input  logic                clk,
    input  logic                reset,
    conv_ctrl_if.datapath       ctrl,
    input  fft_conv_pkg::prod_t prod_re [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    input  fft_conv_pkg::prod_t prod_im [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    output fft_conv_pkg::idft_t block [fft_conv_pkg::OUT_SIZE][fft_conv_pkg::OUT_SIZE]
);

    localparam int N = fft_conv_pkg::TILE_SIZE;
    localparam int M = fft_conv_pkg::OUT_SIZE;
    // first row and column of the valid block
    localparam int OFS = N - M;

    // first pass results for the kept rows only
    fft_conv_pkg::idft_t pass_re [M][N];
    fft_conv_pkg::idft_t pass_im [M][N];
    fft_conv_pkg::idft_t kept    [M][M];
    logic                frac_nonzero;

    // ==============================
    // inverse transform
    // ==============================

    // conjugate twiddles, so every imaginary table term flips sign
    always_comb begin
        // first pass down the rows, complex in and out
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < N; j++) begin
                pass_re[i][j] = '0;
                pass_im[i][j] = '0;
                for (int k = 0; k < N; k++) begin
                    pass_re[i][j] += fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_RE[i+OFS][k])
                                   * fft_conv_pkg::idft_t'(prod_re[k][j])
                                   + fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_IM[i+OFS][k])
                                   * fft_conv_pkg::idft_t'(prod_im[k][j]);
                    pass_im[i][j] += fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_RE[i+OFS][k])
                                   * fft_conv_pkg::idft_t'(prod_im[k][j])
                                   - fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_IM[i+OFS][k])
                                   * fft_conv_pkg::idft_t'(prod_re[k][j]);
                end
            end
        end
        // second pass along the columns, only the real part of the kept block
        frac_nonzero = 1'b0;
        for (int i = 0; i < M; i++) begin
            for (int j = 0; j < M; j++) begin
                kept[i][j] = '0;
                for (int k = 0; k < N; k++) begin
                    kept[i][j] += fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_RE[k][j+OFS])
                                * pass_re[i][k]
                                + fft_conv_pkg::idft_t'(fft_conv_pkg::TWIDDLE_IM[k][j+OFS])
                                * pass_im[i][k];
                end
                frac_nonzero = frac_nonzero | (|kept[i][j][3:0]);
            end
        end
    end

    // divide by 16 leaves no remainder for integer inputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            block <= '{default: '0};
        end else if (ctrl.inverse_en) begin
            for (int i = 0; i < M; i++) begin
                for (int j = 0; j < M; j++) begin
                    block[i][j] <= kept[i][j] >>> 4;
                end
            end
        end
    end

    // a remainder here means a width overflow somewhere upstream
    assert property (@(posedge clk) disable iff (reset) ctrl.inverse_en |-> !frac_nonzero)
        else $error("inverse sum not a multiple of 16");

endmodule

`default_nettype wire

// File: transform/spectral_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module spectral_multiplier (
    input  logic                clk,
    input  logic                reset,
    conv_ctrl_if.datapath       ctrl,
    input  fft_conv_pkg::spec_t tile_re [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    input  fft_conv_pkg::spec_t tile_im [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    input  fft_conv_pkg::spec_t kern_re [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    input  fft_conv_pkg::spec_t kern_im [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    output fft_conv_pkg::prod_t prod_re [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE],
    output fft_conv_pkg::prod_t prod_im [fft_conv_pkg::TILE_SIZE][fft_conv_pkg::TILE_SIZE]
);

    localparam int N = fft_conv_pkg::TILE_SIZE;

    fft_conv_pkg::prod_t mul_re [N][N];
    fft_conv_pkg::prod_t mul_im [N][N];

    // three multiplies per bin
    // p = a_im * (b_re - b_im)
    // q = b_re * (a_re - a_im)
    // r = b_im * (a_re + a_im)
    // re = p + q, im = p + r
    always_comb begin
        fft_conv_pkg::prod_t p;
        fft_conv_pkg::prod_t q;
        fft_conv_pkg::prod_t r;
        for (int l = 0; l < N; l++) begin
            for (int k = 0; k < N; k++) begin
                p = fft_conv_pkg::prod_t'(tile_im[l][k])
                  * (fft_conv_pkg::prod_t'(kern_re[l][k]) - fft_conv_pkg::prod_t'(kern_im[l][k]));
                q = fft_conv_pkg::prod_t'(kern_re[l][k])
                  * (fft_conv_pkg::prod_t'(tile_re[l][k]) - fft_conv_pkg::prod_t'(tile_im[l][k]));
                r = fft_conv_pkg::prod_t'(kern_im[l][k])
                  * (fft_conv_pkg::prod_t'(tile_re[l][k]) + fft_conv_pkg::prod_t'(tile_im[l][k]));
                mul_re[l][k] = p + q;
                mul_im[l][k] = p + r;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_re <= '{default: '0};
            prod_im <= '{default: '0};
        end else if (ctrl.multiply_en) begin
            prod_re <= mul_re;
            prod_im <= mul_im;
        end
    end

endmodule

`default_nettype wire
